/* test/lod_golden.hex */
// tree_count cam_x cam_y cam_z s dist_max sram_word0 sram_word1 mask
// word0 = x y z dl0, word1 = dl1 dl2 dl3 dl4, mask bit i = level i
0000 4000 4400 bc00 3c00 3c00 40004400bc000000 0000000000000000 1f
0005 5000 0000 0000 3c00 3c00 0000000000000000 0000000000000000 00
0002 3c00 0000 0000 3c00 3c00 0000000000003c00 00004400c0004600 15
0007 3c00 0000 0000 3c00 4800 000000000000c200 bc0000003c00c200 0e
0003 0000 4000 0000 4000 4c00 0000000000003800 bc003c0040004200 1d
0001 3c00 3c00 3c00 3c00 4400 0000000000000000 3a00000000004400 11
0010 4400 0000 0000 3800 5400 450000000000c000 c000c000c000c000 1f
0004 0000 0000 4800 4400 3c00 0000000000004400 4700460049000000 0a

/* vlog.f */
+incdir+hw
hw/lod_pkg.sv
hw/fp16_add.sv
hw/fp16_mult.sv
hw/fp16_log2.sv
hw/lod_fetch.sv
hw/lod_level_eval.sv
hw/lod_compute.sv
test/tb_lod_compute.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_lod_compute
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_lod_compute.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lod_config.svh"

module tb_lod_compute
    import lod_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_JOBS       = 8;
    localparam int FIELDS         = 9;
    localparam int READY_DELAY    = 14;
    localparam int IDLE_GAP       = 3;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * 40 + 100;

    // field order of one golden line
    localparam int F_TREE  = 0;
    localparam int F_CAM_X = 1;
    localparam int F_CAM_Y = 2;
    localparam int F_CAM_Z = 3;
    localparam int F_S     = 4;
    localparam int F_DMAX  = 5;
    localparam int F_WORD0 = 6;
    localparam int F_WORD1 = 7;
    localparam int F_MASK  = 8;

    logic                        clk;
    logic                        rst_n;
    logic                        cal_lod;
    logic [`LOD_ADDR_WIDTH-1:0]  tree_count;
    vec3_t                       cam_pos;
    fp16_t                       s;
    fp16_t                       dist_max;
    sram_word_u                  sram_q;
    logic                        sram_cen;
    logic [`LOD_ADDR_WIDTH-1:0]  sram_addr;
    logic                        lod_ready;
    logic [`LOD_TREE_LEVELS-1:0] lod_active;

    logic [`LOD_WORD_WIDTH-1:0]  golden [NUM_JOBS*FIELDS];
    int                          cur_job;
    logic                        rd_pending;
    logic [`LOD_ADDR_WIDTH-1:0]  rd_addr;

    lod_compute lod_compute_inst (
        .clk,
        .rst_n,
        .cal_lod,
        .tree_count,
        .cam_pos,
        .s,
        .dist_max,
        .sram_q,
        .sram_cen,
        .sram_addr,
        .lod_ready,
        .lod_active
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [15:0] record_addr(input int j);
        logic [15:0] tc;
        tc = golden[j*FIELDS+F_TREE][15:0];
        return 16'(`LOD_START_ADDR + 2 * tc);
    endfunction

    // only the two words of the current octree are mapped
    function automatic logic [63:0] word_at(input logic [15:0] addr);
        logic [15:0] base;
        base = record_addr(cur_job);
        if (addr == base) begin
            return golden[cur_job*FIELDS+F_WORD0];
        end else if (addr == base + 16'd1) begin
            return golden[cur_job*FIELDS+F_WORD1];
        end else begin
            return 'x;
        end
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_quiet();
        check_eq("lod_ready", lod_ready, 0);
        check_eq("lod_active", lod_active, 0);
    endtask

    // sram model returns the word one cycle after the address
    always @(negedge clk) begin
        if (rd_pending) begin
            sram_q = word_at(rd_addr);
        end
        rd_pending = !sram_cen;
        rd_addr    = sram_addr;
    end

    //////////////////////////////////////////////////
    // one job from the golden file
    //////////////////////////////////////////////////
    task automatic run_job(input int j, input int gap, input bit keep_high);
        logic [15:0] base;
        logic [63:0] exp_mask;
        base     = record_addr(j);
        exp_mask = golden[j*FIELDS+F_MASK];
        repeat (gap) begin
            @(negedge clk);
            check_eq("sram_cen", sram_cen, 1);
            check_quiet();
        end
        @(negedge clk);
        cur_job    = j;
        tree_count = golden[j*FIELDS+F_TREE][15:0];
        cam_pos.x  = golden[j*FIELDS+F_CAM_X][15:0];
        cam_pos.y  = golden[j*FIELDS+F_CAM_Y][15:0];
        cam_pos.z  = golden[j*FIELDS+F_CAM_Z][15:0];
        s          = golden[j*FIELDS+F_S][15:0];
        dist_max   = golden[j*FIELDS+F_DMAX][15:0];
        cal_lod    = 1'b1;

        // the first low sram_cen marks the start edge
        while (sram_cen) begin
            check_quiet();
            @(negedge clk);
        end
        check_eq("sram_addr", sram_addr, base);
        for (int k = 1; k <= READY_DELAY; k++) begin
            @(negedge clk);
            if (k == 1) begin
                check_eq("sram_cen", sram_cen, 0);
                check_eq("sram_addr", sram_addr, base + 16'd1);
            end else begin
                check_eq("sram_cen", sram_cen, 1);
            end
            if (k < READY_DELAY) begin
                check_quiet();
            end else begin
                check_eq("lod_ready", lod_ready, 1);
                check_eq("lod_active", lod_active, exp_mask);
                if (!keep_high) begin
                    cal_lod = 1'b0;
                end
            end
        end
    endtask

    initial begin
        bit keep;
        int gap;
        $readmemh("test/lod_golden.hex", golden);
        rst_n      = 1'b0;
        cal_lod    = 1'b0;
        tree_count = '0;
        cam_pos    = '0;
        s          = '0;
        dist_max   = '0;
        sram_q     = '0;
        rd_pending = 1'b0;
        rd_addr    = '0;
        cur_job    = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle outputs before the first job
        repeat (3) begin
            @(negedge clk);
            check_eq("sram_cen", sram_cen, 1);
            check_eq("sram_addr", sram_addr, 0);
            check_quiet();
        end

        gap = IDLE_GAP;
        for (int j = 0; j < NUM_JOBS; j++) begin
            // jobs 1 to 3 and 5 to 7 run back to back with cal_lod held
            keep = (j % 4 == 1 || j % 4 == 2);
            run_job(j, gap, keep);
            gap = keep ? 0 : IDLE_GAP;
        end

        repeat (IDLE_GAP) begin
            @(negedge clk);
            check_eq("sram_cen", sram_cen, 1);
            check_quiet();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the jobs did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* hw/lod_compute.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lod_config.svh"

module lod_compute
    import lod_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cal_lod,
    input  logic [`LOD_ADDR_WIDTH-1:0]  tree_count,
    input  vec3_t                       cam_pos,
    input  fp16_t                       s,
    input  fp16_t                       dist_max,
    input  sram_word_u                  sram_q,
    output logic                        sram_cen,
    output logic [`LOD_ADDR_WIDTH-1:0]  sram_addr,
    output logic                        lod_ready,
    output logic [`LOD_TREE_LEVELS-1:0] lod_active
);

    oct_rec_t                    rec;
    logic                        rec_valid;
    logic [`LOD_TREE_LEVELS-1:0] mask;
    logic                        mask_valid;

    // mask_valid also releases the fetch FSM
    lod_fetch u_fetch (
        .clk,
        .rst_n,
        .cal_lod,
        .tree_count,
        .done      (mask_valid),
        .sram_q,
        .sram_cen,
        .sram_addr,
        .rec,
        .rec_valid
    );

    lod_level_eval u_eval (
        .clk,
        .rst_n,
        .cam_pos,
        .s,
        .dist_max,
        .rec,
        .rec_valid,
        .mask,
        .mask_valid
    );

    // result only shows in the ready cycle
    assign lod_ready  = mask_valid;
    assign lod_active = mask_valid ? mask : '0;

endmodule

`default_nettype wire

/* hw/lod_level_eval.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lod_config.svh"

module lod_level_eval
    import lod_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  vec3_t                       cam_pos,
    input  fp16_t                       s,
    input  fp16_t                       dist_max,
    input  oct_rec_t                    rec,
    input  logic                        rec_valid,
    output logic [`LOD_TREE_LEVELS-1:0] mask,
    output logic                        mask_valid
);

    localparam int    DL_DEPTH = `LOD_EVAL_LATENCY - 2;
    localparam fp16_t HALF     = 16'h3800;
    // -(i+1) for each level
    localparam fp16_t LEVEL_NEG [`LOD_TREE_LEVELS] = '{
        16'hbc00, 16'hc000, 16'hc200, 16'hc400, 16'hc500
    };

    fp16_t [2:0]                  cam_v;
    fp16_t [2:0]                  pos_v;
    fp16_t [2:0]                  diff;
    fp16_t [2:0]                  sq;
    fp16_t                        sq_z_q;
    fp16_t                        sum_xy;
    fp16_t                        sum_xyz;
    fp16_t                        log_d2;
    fp16_t                        log_dmax;
    fp16_t                        log_s;
    fp16_t                        half_log;
    fp16_t                        base_a;
    fp16_t                        base_b;
    fp16_t [`LOD_TREE_LEVELS-1:0] dl_pipe [DL_DEPTH];
    logic [`LOD_EVAL_LATENCY-1:0] vld;

    // index 2 is x, 0 is z
    assign cam_v = cam_pos;
    assign pos_v = rec.pos;

    //////////////////////////////////////////////////
    // squared distance
    //////////////////////////////////////////////////
    for (genvar i = 0; i < 3; i++) begin : g_axis
        fp16_add u_diff (
            .clk,
            .rst_n,
            .a   (cam_v[i]),
            .b   ({~pos_v[i].sign, pos_v[i].exp, pos_v[i].mant}),
            .sum (diff[i])
        );
        fp16_mult u_sq (.clk, .rst_n, .a(diff[i]), .b(diff[i]), .prod(sq[i]));
    end

    fp16_add u_sum_xy (.clk, .rst_n, .a(sq[2]), .b(sq[1]), .sum(sum_xy));
    fp16_add u_sum_xyz (.clk, .rst_n, .a(sum_xy), .b(sq_z_q), .sum(sum_xyz));

    // log terms, dist_max and s are steady for the whole job
    fp16_log2 u_log_d2 (.clk, .rst_n, .x(sum_xyz), .y(log_d2));
    fp16_log2 u_log_dmax (.clk, .rst_n, .x(dist_max), .y(log_dmax));
    fp16_log2 u_log_s (.clk, .rst_n, .x(s), .y(log_s));

    fp16_mult u_half (.clk, .rst_n, .a(log_d2), .b(HALF), .prod(half_log));

    //////////////////////////////////////////////////
    // base and per-level tests
    //////////////////////////////////////////////////
    fp16_add u_base_a (
        .clk,
        .rst_n,
        .a   (log_dmax),
        .b   ({~half_log.sign, half_log.exp, half_log.mant}),
        .sum (base_a)
    );
    fp16_add u_base_b (
        .clk,
        .rst_n,
        .a   (base_a),
        .b   ({~log_s.sign, log_s.exp, log_s.mant}),
        .sum (base_b)
    );

    for (genvar i = 0; i < `LOD_TREE_LEVELS; i++) begin : g_level
        fp16_t with_off;
        fp16_t final_v;

        fp16_add u_off (
            .clk,
            .rst_n,
            .a   (base_b),
            .b   (dl_pipe[DL_DEPTH-1][i]),
            .sum (with_off)
        );
        fp16_add u_lvl (.clk, .rst_n, .a(with_off), .b(LEVEL_NEG[i]), .sum(final_v));

        // active when not negative
        assign mask[i] = ~final_v.sign;
    end

    // z square waits one cycle for x plus y, offsets wait for the base
    always_ff @(posedge clk) begin
        sq_z_q     <= sq[0];
        dl_pipe[0] <= rec.dl;
        for (int k = 1; k < DL_DEPTH; k++) begin
            dl_pipe[k] <= dl_pipe[k-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[`LOD_EVAL_LATENCY-2:0], rec_valid};
        end
    end

    assign mask_valid = vld[`LOD_EVAL_LATENCY-1];

endmodule

`default_nettype wire

/* hw/lod_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lod_config.svh"

module lod_fetch
    import lod_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cal_lod,
    input  logic [`LOD_ADDR_WIDTH-1:0] tree_count,
    input  logic                       done,
    input  sram_word_u                 sram_q,
    output logic                       sram_cen,
    output logic [`LOD_ADDR_WIDTH-1:0] sram_addr,
    output oct_rec_t                   rec,
    output logic                       rec_valid
);

    typedef enum logic [2:0] {
        IDLE,
        READ0,
        READ1,
        CAPTURE,
        BUSY
    } state_t;

    state_t                     state;
    logic [`LOD_ADDR_WIDTH-1:0] addr0;

    // even word of octree n
    assign addr0 = `LOD_START_ADDR + {tree_count[`LOD_ADDR_WIDTH-2:0], 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            sram_cen  <= 1'b1;
            sram_addr <= '0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (cal_lod) begin
                        state     <= READ0;
                        sram_cen  <= 1'b0;
                        sram_addr <= addr0;
                    end
                end
                READ0: begin
                    state     <= READ1;
                    sram_addr <= addr0 + 1'b1;
                end
                READ1: begin
                    state    <= CAPTURE;
                    sram_cen <= 1'b1;
                end
                CAPTURE: begin
                    state     <= BUSY;
                    rec_valid <= 1'b1;
                end
                // hold until the mask is out
                BUSY: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // word 0 arrives in READ1, word 1 in CAPTURE
    always_ff @(posedge clk) begin
        if (state == READ1) begin
            rec.pos.x <= sram_q.pos.x;
            rec.pos.y <= sram_q.pos.y;
            rec.pos.z <= sram_q.pos.z;
            rec.dl[0] <= sram_q.pos.dl0;
        end
        if (state == CAPTURE) begin
            rec.dl[1] <= sram_q.layer.dl1;
            rec.dl[2] <= sram_q.layer.dl2;
            rec.dl[3] <= sram_q.layer.dl3;
            rec.dl[4] <= sram_q.layer.dl4;
        end
    end

endmodule

`default_nettype wire

/* hw/fp16_log2.sv */
`timescale 1ns/100ps
`default_nettype none

module fp16_log2
    import lod_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  fp16_t x,
    output fp16_t y
);

    localparam fp16_t LOG_NEG = 16'h7c01;

    // fp16 of 0..16 for the integer part
    function automatic fp16_t int_lut(input logic [4:0] n);
        case (n)
            5'd1:    int_lut = 16'h3c00;
            5'd2:    int_lut = 16'h4000;
            5'd3:    int_lut = 16'h4200;
            5'd4:    int_lut = 16'h4400;
            5'd5:    int_lut = 16'h4500;
            5'd6:    int_lut = 16'h4600;
            5'd7:    int_lut = 16'h4700;
            5'd8:    int_lut = 16'h4800;
            5'd9:    int_lut = 16'h4880;
            5'd10:   int_lut = 16'h4900;
            5'd11:   int_lut = 16'h4980;
            5'd12:   int_lut = 16'h4a00;
            5'd13:   int_lut = 16'h4a80;
            5'd14:   int_lut = 16'h4b00;
            5'd15:   int_lut = 16'h4b80;
            5'd16:   int_lut = 16'h4c00;
            default: int_lut = 16'h0000;
        endcase
    endfunction

    // log2(1 + i/16) in sixteenths
    function automatic fp16_t frac_lut(input logic [3:0] idx);
        case (idx)
            4'd1:    frac_lut = 16'h2c00;
            4'd2:    frac_lut = 16'h3200;
            4'd3:    frac_lut = 16'h3400;
            4'd4:    frac_lut = 16'h3500;
            4'd5:    frac_lut = 16'h3600;
            4'd6:    frac_lut = 16'h3700;
            4'd7:    frac_lut = 16'h3800;
            4'd8:    frac_lut = 16'h3880;
            4'd9:    frac_lut = 16'h3900;
            4'd10:   frac_lut = 16'h3980;
            4'd11:   frac_lut = 16'h3a00;
            4'd12:   frac_lut = 16'h3a80;
            4'd13:   frac_lut = 16'h3b00;
            4'd14:   frac_lut = 16'h3b80;
            4'd15:   frac_lut = 16'h3b80;
            default: frac_lut = 16'h0000;
        endcase
    endfunction

    logic       below;
    logic [4:0] e_mag;
    fp16_t      int_fp;
    fp16_t      int_q;
    fp16_t      frac_q;
    fp16_t      sum_q;
    logic       neg_q1;
    logic       neg_q2;

    // unbiased exponent as sign and magnitude
    always_comb begin
        below       = x.exp < 5'd15;
        e_mag       = below ? 5'd15 - x.exp : x.exp - 5'd15;
        int_fp      = int_lut(e_mag);
        int_fp.sign = below;
    end

    //////////////////////////////////////////////////
    // stage one, table lookups
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_q  <= '0;
            frac_q <= '0;
            neg_q1 <= 1'b0;
            neg_q2 <= 1'b0;
        end else begin
            int_q  <= int_fp;
            frac_q <= frac_lut(x.mant[9:6]);
            neg_q1 <= x.sign;
            neg_q2 <= neg_q1;
        end
    end

    // stage two, integer plus fraction
    fp16_add u_add (
        .clk,
        .rst_n,
        .a   (int_q),
        .b   (frac_q),
        .sum (sum_q)
    );

    assign y = neg_q2 ? LOG_NEG : sum_q;

endmodule

`default_nettype wire

/* hw/fp16_mult.sv */
`timescale 1ns/100ps
`default_nettype none

module fp16_mult
    import lod_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  fp16_t a,
    input  fp16_t b,
    output fp16_t prod
);

    logic [21:0] frac_p;
    logic [6:0]  exp_r;
    logic [9:0]  mant;
    fp16_t       res;

    always_comb begin
        frac_p = {1'b1, a.mant} * {1'b1, b.mant};
        // rebias, one bias too many after the add
        exp_r  = {2'b00, a.exp} + {2'b00, b.exp} - 7'd15;

        // product of two hidden-bit fractions lies in [1, 4)
        if (frac_p[21]) begin
            mant  = frac_p[20:11];
            exp_r = exp_r + 7'd1;
        end else begin
            mant  = frac_p[19:10];
        end

        if ((a.exp == '0 && a.mant == '0) || (b.exp == '0 && b.mant == '0)) begin
            res = '0;
        end else if (exp_r[4:0] == 5'd1) begin
            res = '0;
        end else begin
            res = {a.sign ^ b.sign, exp_r[4:0], mant};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod <= '0;
        end else begin
            prod <= res;
        end
    end

endmodule

`default_nettype wire

/* hw/fp16_add.sv */
`timescale 1ns/100ps
`default_nettype none

module fp16_add
    import lod_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  fp16_t a,
    input  fp16_t b,
    output fp16_t sum
);

    logic [10:0] frac_a;
    logic [10:0] frac_b;
    logic [4:0]  shift;
    logic [11:0] mag;
    logic [6:0]  exp_r;
    logic [3:0]  lz;
    logic        sgn;
    fp16_t       res;

    always_comb begin
        frac_a = {1'b1, a.mant};
        frac_b = {1'b1, b.mant};
        exp_r  = {2'b00, a.exp};
        shift  = '0;
        mag    = '0;
        lz     = '0;
        sgn    = a.sign;

        // align the smaller operand
        if (b.exp > a.exp) begin
            shift  = b.exp - a.exp;
            frac_a = frac_a >> shift;
            exp_r  = {2'b00, b.exp};
        end else begin
            shift  = a.exp - b.exp;
            frac_b = frac_b >> shift;
        end

        if (a.sign == b.sign) begin
            mag = {1'b0, frac_a} + {1'b0, frac_b};
        end else if (a.sign) begin
            mag = {1'b0, frac_b} - {1'b0, frac_a};
        end else begin
            mag = {1'b0, frac_a} - {1'b0, frac_b};
        end

        // borrow gives the sign, back to magnitude
        if (a.sign != b.sign) begin
            sgn = mag[11];
            if (mag[11]) begin
                mag = -mag;
            end
        end

        // carry out or leading-one search
        if (mag[11]) begin
            mag   = mag >> 1;
            exp_r = exp_r + 7'd1;
        end else begin
            for (int k = 0; k < 11; k++) begin
                if (mag[k]) begin
                    lz = 4'(10 - k);
                end
            end
            mag   = mag << lz;
            exp_r = exp_r - {3'b000, lz};
        end

        // special cases, zero checks ignore the sign
        if (a.exp == '0 && a.mant == '0) begin
            res = b;
        end else if (b.exp == '0 && b.mant == '0) begin
            res = a;
        end else if ({a.exp, a.mant} == {b.exp, b.mant} && a.sign != b.sign) begin
            res = '0;
        end else if (exp_r[4:0] == 5'd1) begin
            res = '0;
        end else begin
            res = {sgn, exp_r[4:0], mag[9:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else begin
            sum <= res;
        end
    end

endmodule

`default_nettype wire

/* hw/lod_pkg.sv */
`default_nettype none

`include "lod_config.svh"

package lod_pkg;

    // half precision, no subnormals
    typedef struct packed {
        logic                     sign;
        logic [4:0]               exp;
        logic [`LOD_FP_WIDTH-7:0] mant;
    } fp16_t;

    typedef struct packed {
        fp16_t x;
        fp16_t y;
        fp16_t z;
    } vec3_t;

    // even word of a record
    typedef struct packed {
        fp16_t x;
        fp16_t y;
        fp16_t z;
        fp16_t dl0;
    } pos_word_t;

    // odd word of a record
    typedef struct packed {
        fp16_t dl1;
        fp16_t dl2;
        fp16_t dl3;
        fp16_t dl4;
    } layer_word_t;

    // one sram word, decoded by address parity
    typedef union packed {
        pos_word_t   pos;
        layer_word_t layer;
    } sram_word_u;

    typedef struct packed {
        vec3_t                              pos;
        fp16_t [`LOD_TREE_LEVELS-1:0]       dl;
    } oct_rec_t;

endpackage

`default_nettype wire

/* hw/lod_config.svh */
`ifndef LOD_CONFIG_SVH
`define LOD_CONFIG_SVH

// fp16 word width
`define LOD_FP_WIDTH 16

// sram interface
`define LOD_ADDR_WIDTH 16
`define LOD_WORD_WIDTH 64

// octree levels evaluated per job
`define LOD_TREE_LEVELS 5

// record table base, octree n sits at base + 2n and base + 2n + 1
`define LOD_START_ADDR 16'h0100

// cycles from rec_valid to mask_valid
`define LOD_EVAL_LATENCY 11

`endif
